//--- link_ctl_pkg.sv
/*
 * Shared definitions for the host-link router
 * Link word constants, type tags and FIFO entry layout
 * Register map constants for the control register file
 * Received-word union with header and command views
 */

package link_ctl_pkg;

    // ----------------------------------------
    // Link word layout
    // ----------------------------------------
    localparam int LINK_W = 64;                     // Host link word
    localparam int ITEM_W = 32;                     // Payload item
    localparam int CTX_W  = 2;                      // Context field, bits 11:10

    localparam logic [7:0] LINK_MAGIC = 8'h77;      // Marks a valid word, bits 7:0

    // Type field, bits 9:8
    typedef enum logic [1:0] {
        TAG_TLP  = 2'b00,                           // Discarded on receive
        TAG_CFG  = 2'b01,                           // Discarded on receive
        TAG_LOOP = 2'b10,
        TAG_CMD  = 2'b11
    } link_tag_e;

    // FIFO entry for loopback and response sources
    typedef struct packed {
        logic [CTX_W-1:0]  ctx;
        logic [ITEM_W-1:0] data;
    } src_item_t;

    // General view of a received word
    typedef struct packed {
        logic [ITEM_W-1:0] payload;                 // 63:32
        logic [15:0]       addr;                    // 31:16
        logic [3:0]        flags;                   // 15:12
        logic [CTX_W-1:0]  ctx;                     // 11:10
        link_tag_e         tag;                     // 9:8
        logic [7:0]        magic;                   // 7:0
    } link_hdr_t;

    // Command view, mask and value bytes arrive swapped
    typedef struct packed {
        logic [7:0]  value_b7;
        logic [7:0]  value_b6;
        logic [7:0]  mask_b5;
        logic [7:0]  mask_b4;
        logic [15:0] addr;                          // Byte address
        logic [1:0]  rsvd;
        logic        wr;                            // Bit 13
        logic        rd;                            // Bit 12
        logic [11:0] hdr;                           // Magic, tag, context
    } link_cmd_t;

    typedef union packed {
        link_hdr_t hdr;
        link_cmd_t cmd;
    } link_word_u;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [15:0] RO_MAGIC = 16'hab89;    // Read-only page +0
    localparam logic [15:0] RW_MAGIC = 16'hefcd;    // Read-write page +0 after reset
    localparam int RO_BYTES    = 16;
    localparam int RW_BYTES    = 16;
    localparam int ADDR_RW_BIT = 15;                // Page select in byte address

endpackage

//--- link_src_if.sv
/*
 * FIFO source interface read by a consumer
 * Show-ahead: item is the head while valid, rd_en pops it
 */

`timescale 1ns/1ns

interface link_src_if
    import link_ctl_pkg::*;
#(
    parameter type ITEM_T = src_item_t              // Entry type carried
) ();

    ITEM_T item;                                    // Head entry
    logic  valid;                                   // FIFO not empty
    logic  rd_en;                                   // Pop request
    logic  almost_full;                             // One free slot left

    modport fifo (output item, output valid, output almost_full, input rd_en);
    modport arb  (input item, input valid, input almost_full, output rd_en);

endinterface

//--- sync_fifo.sv
/*
 * Synchronous show-ahead FIFO
 * Circular buffer, almost-full at one free slot
 * Writes into a full FIFO are dropped
 */

`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 16                        // Power of two
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_din,
    link_src_if.fifo         o_src
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;                        // Occupancy, 0..DEPTH

    logic full;
    logic do_wr;
    logic do_rd;

    assign full  = (count == (AW+1)'(DEPTH));
    assign do_wr = i_wr_en & ~full;                 // Lost when full
    assign do_rd = o_src.rd_en & o_src.valid;       // Pop only a real entry

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= i_din;
    end

    // Show-ahead head
    assign o_src.item        = mem[rd_ptr];
    assign o_src.valid       = (count != '0);
    assign o_src.almost_full = (count >= (AW+1)'(DEPTH - 1));

endmodule

//--- rx_router.sv
/*
 * Receive router
 * Registers link words, checks magic and type
 * Writes loopback and command FIFOs, drops other types
 */

`timescale 1ns/1ns

module rx_router
    import link_ctl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rx_valid,
    input  link_word_u i_rx_word,
    output logic       o_loop_wr,
    output src_item_t  o_loop_din,
    output logic       o_cmd_wr,
    output link_word_u o_cmd_din
);

    link_word_u rx_q;                               // Registered word
    logic       rx_vld_q;
    logic       magic_ok;

    always_ff @(posedge clk)
    begin
        if (rst)
            rx_vld_q <= 1'b0;
        else
            rx_vld_q <= i_rx_valid;
    end

    always_ff @(posedge clk)
    begin
        rx_q <= i_rx_word;                          // Payload, no reset
    end

    assign magic_ok = rx_vld_q & (rx_q.hdr.magic == LINK_MAGIC);

    // At most one enable per word, PCIe types have no path here
    assign o_loop_wr = magic_ok & (rx_q.hdr.tag == TAG_LOOP);
    assign o_cmd_wr  = magic_ok & (rx_q.hdr.tag == TAG_CMD);

    assign o_loop_din = '{ctx: rx_q.hdr.ctx, data: rx_q.hdr.payload};
    assign o_cmd_din  = rx_q;                       // Decoded by the regfile

endmodule

//--- ctl_regfile.sv
/*
 * Control register file
 * Command decode from the command input FIFO
 * Read-only page with magic, byte count, version and ids
 * Read-write page with magic, byte count and scratch bytes
 * Response writer, one entry per read
 */

`timescale 1ns/1ns

module ctl_regfile
    import link_ctl_pkg::*;
#(
    parameter logic [7:0]  VERSION_MAJOR = 8'd0,
    parameter logic [7:0]  VERSION_MINOR = 8'd0,
    parameter logic [7:0]  DEVICE_ID     = 8'd0,
    parameter logic [31:0] CUSTOM_VALUE  = 32'd0
) (
    input  logic      clk,
    input  logic      rst,
    link_src_if.arb   i_cmd,                        // Command input FIFO
    output logic      o_rsp_wr,
    output src_item_t o_rsp_din,
    input  logic      i_rsp_afull                   // Response FIFO almost full
);

    localparam int RO_W = RO_BYTES * 8;
    localparam int RW_W = RW_BYTES * 8;

    logic [RO_W-1:0] ro_page;
    logic [RW_W-1:0] rw_page;

    link_word_u  cmd;
    logic        pop;
    logic [15:0] addr;
    logic        f_rw;                              // Read-write page selected
    logic [6:0]  bit_off;                           // Bit offset within page
    logic        ro_hit;
    logic        rw_hit;
    logic [15:0] in_mask;
    logic [15:0] in_value;
    logic [15:0] rd_val;
    logic        wr_cmd;
    logic [RW_W-1:0] mask_sh;
    logic [RW_W-1:0] val_sh;

    // ----------------------------------------
    // Read-only page
    // ----------------------------------------
    assign ro_page = {
        CUSTOM_VALUE,                               // +C
        8'h00,                                      // +B slack
        DEVICE_ID,                                  // +A
        VERSION_MINOR,                              // +9
        VERSION_MAJOR,                              // +8
        32'(RO_BYTES),                              // +4 byte count, little endian
        16'h0000,                                   // +2
        RO_MAGIC                                    // +0
    };

    // ----------------------------------------
    // Command decode
    // ----------------------------------------
    assign cmd  = i_cmd.item;
    assign pop  = i_cmd.valid & ~i_rsp_afull;       // Room for the response
    assign i_cmd.rd_en = pop;

    assign addr    = cmd.cmd.addr;
    assign f_rw    = addr[ADDR_RW_BIT];
    assign bit_off = {addr[3:0], 3'b000};

    // Whole 16-bit access must fit inside the page
    assign ro_hit = (addr[14:0] <= 15'(RO_BYTES - 2));
    assign rw_hit = (addr[14:0] <= 15'(RW_BYTES - 2));

    // Mask and value bytes arrive swapped
    assign in_mask  = {cmd.cmd.mask_b4, cmd.cmd.mask_b5};
    assign in_value = {cmd.cmd.value_b6, cmd.cmd.value_b7};

    always_comb
    begin
        if (f_rw)
            rd_val = rw_hit ? rw_page[bit_off +: 16] : 16'h0000;
        else
            rd_val = ro_hit ? ro_page[bit_off +: 16] : 16'h0000;
    end

    // Writes only on the read-write page
    assign wr_cmd  = pop & cmd.cmd.wr & f_rw & rw_hit;
    assign mask_sh = RW_W'(in_mask) << bit_off;
    assign val_sh  = RW_W'(in_value & in_mask) << bit_off;

    // ----------------------------------------
    // Read-write page
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rw_page <= '0;                          // Scratch bytes clear
            rw_page[15:0]  <= RW_MAGIC;             // +0
            rw_page[31:16] <= 16'(RW_BYTES);        // +2 byte count
        end
        else if (wr_cmd)
            rw_page <= (rw_page & ~mask_sh) | val_sh;   // Masked bits only
    end

    // ----------------------------------------
    // Response writer
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            o_rsp_wr <= 1'b0;
        else
            o_rsp_wr <= pop & cmd.cmd.rd;           // Reads only
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            o_rsp_din.ctx  <= cmd.hdr.ctx;          // Context echoed back
            o_rsp_din.data <= {addr, rd_val[7:0], rd_val[15:8]};
        end
    end

endmodule

//--- tx_arbiter.sv
/*
 * Transmit arbiter
 * Fixed priority, loopback first, responses second
 * Output word formatting and credit counter
 */

`timescale 1ns/1ns

module tx_arbiter
    import link_ctl_pkg::*;
#(
    parameter int TX_CREDITS = 4                    // Credits after reset
) (
    input  logic              clk,
    input  logic              rst,
    link_src_if.arb           i_loop,               // Loopback FIFO
    link_src_if.arb           i_rsp,                // Response FIFO
    input  logic              i_tx_credit,          // One credit per high cycle
    output logic              o_tx_valid,
    output logic [LINK_W-1:0] o_tx_word
);

    localparam int CW = $clog2(TX_CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          has_credit;
    logic          pop_loop;
    logic          pop_rsp;
    logic          pop_any;
    src_item_t     sel_item;
    link_tag_e     sel_tag;

    // ----------------------------------------
    // Selection
    // ----------------------------------------
    assign has_credit = (credit_cnt != '0);
    assign pop_loop   = has_credit & i_loop.valid;
    assign pop_rsp    = has_credit & ~i_loop.valid & i_rsp.valid;   // Only when loopback idle
    assign pop_any    = pop_loop | pop_rsp;

    assign i_loop.rd_en = pop_loop;
    assign i_rsp.rd_en  = pop_rsp;

    assign sel_item = pop_loop ? i_loop.item : i_rsp.item;
    assign sel_tag  = pop_loop ? TAG_LOOP : TAG_CMD;

    // ----------------------------------------
    // Credit counter
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            credit_cnt <= CW'(TX_CREDITS);
        else
        begin
            case ({pop_any, i_tx_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;   // Word sent
                2'b01:   credit_cnt <= credit_cnt + 1'b1;   // Credit back
                default: credit_cnt <= credit_cnt;          // Cancel out
            endcase
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            o_tx_valid <= 1'b0;
        else
            o_tx_valid <= pop_any;                  // One cycle after pop
    end

    always_ff @(posedge clk)
    begin
        if (pop_any)
            o_tx_word <= {sel_item.data,            // 63:32
                          20'h00000,                // 31:12 unused
                          sel_item.ctx,             // 11:10
                          sel_tag,                  // 9:8
                          LINK_MAGIC};              // 7:0
    end

endmodule

//--- link_ctl_top.sv
/*
 * Host-link router and control block, top level
 * Receive router, loopback, command and response FIFOs
 * Control register file and transmit arbiter
 */

`timescale 1ns/1ns

module link_ctl_top
    import link_ctl_pkg::*;
#(
    parameter logic [7:0]  VERSION_MAJOR = 8'd4,
    parameter logic [7:0]  VERSION_MINOR = 8'd19,
    parameter logic [7:0]  DEVICE_ID     = 8'h03,
    parameter logic [31:0] CUSTOM_VALUE  = 32'h5a5a_c3c3,
    parameter int          TX_CREDITS    = 4,
    parameter int          FIFO_DEPTH    = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rx_valid,
    input  logic [LINK_W-1:0] i_rx_word,
    input  logic              i_tx_credit,
    output logic              o_tx_valid,
    output logic [LINK_W-1:0] o_tx_word
);

    logic       loop_wr;
    src_item_t  loop_din;
    logic       cmd_wr;
    link_word_u cmd_din;
    logic       rsp_wr;
    src_item_t  rsp_din;

    link_src_if                         loop_if ();
    link_src_if #(.ITEM_T(link_word_u)) cmd_if ();
    link_src_if                         rsp_if ();

    // ----------------------------------------
    // Receive side
    // ----------------------------------------
    rx_router u_rx_router (
        .clk        (clk),
        .rst        (rst),
        .i_rx_valid (i_rx_valid),
        .i_rx_word  (i_rx_word),
        .o_loop_wr  (loop_wr),
        .o_loop_din (loop_din),
        .o_cmd_wr   (cmd_wr),
        .o_cmd_din  (cmd_din)
    );

    sync_fifo #(.WIDTH($bits(src_item_t)), .DEPTH(FIFO_DEPTH)) u_loop_fifo (
        .clk (clk), .rst (rst), .i_wr_en (loop_wr), .i_din (loop_din), .o_src (loop_if)
    );

    sync_fifo #(.WIDTH(LINK_W), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .clk (clk), .rst (rst), .i_wr_en (cmd_wr), .i_din (cmd_din), .o_src (cmd_if)
    );

    // ----------------------------------------
    // Command processing
    // ----------------------------------------
    ctl_regfile #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR),
        .DEVICE_ID     (DEVICE_ID),
        .CUSTOM_VALUE  (CUSTOM_VALUE)
    ) u_regfile (
        .clk         (clk),
        .rst         (rst),
        .i_cmd       (cmd_if),
        .o_rsp_wr    (rsp_wr),
        .o_rsp_din   (rsp_din),
        .i_rsp_afull (rsp_if.almost_full)
    );

    sync_fifo #(.WIDTH($bits(src_item_t)), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
        .clk (clk), .rst (rst), .i_wr_en (rsp_wr), .i_din (rsp_din), .o_src (rsp_if)
    );

    // ----------------------------------------
    // Transmit side
    // ----------------------------------------
    tx_arbiter #(.TX_CREDITS(TX_CREDITS)) u_tx_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_loop      (loop_if),
        .i_rsp       (rsp_if),
        .i_tx_credit (i_tx_credit),
        .o_tx_valid  (o_tx_valid),
        .o_tx_word   (o_tx_word)
    );

endmodule

//--- tb_clkgen.sv
/*
 * Testbench clock and synchronous reset generator
 */

`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD     = 10,                  // ns
    parameter int RST_CYCLES = 3                    // Rising edges under reset
) (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;                              // Released on an edge
    end

endmodule

//--- link_ctl_properties.sv
/*
 * Concurrent assertions on the transmit arbiter
 * Credit limits and output behavior during reset
 */

`timescale 1ns/1ns

module link_ctl_properties #(
    parameter int TX_CREDITS = 4,
    parameter int CW         = 3                    // Credit counter width
) (
    input logic          clk,
    input logic          rst,
    input logic [CW-1:0] i_credit_cnt,
    input logic          i_tx_valid
);

    // No pop at zero credits, so nothing leaves a cycle later
    a_no_tx_without_credit: assert property (@(posedge clk) disable iff (rst)
        (i_credit_cnt == '0) |=> !i_tx_valid)
        else $error("Output word sent while the credit count was zero");

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
        i_credit_cnt <= CW'(TX_CREDITS))
        else $error("Credit count above its reset value");

    // Output register cleared by reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !i_tx_valid)
        else $error("o_tx_valid high after a reset cycle");

endmodule

bind tx_arbiter link_ctl_properties #(.TX_CREDITS(TX_CREDITS), .CW(CW)) u_props (
    .clk          (clk),
    .rst          (rst),
    .i_credit_cnt (credit_cnt),
    .i_tx_valid   (o_tx_valid)
);

//--- link_ctl_tb.sv
/*
 * Testbench for the host-link router and control block
 * Directed tests: loopback, filtering, register pages, credits, priority
 * In-order output monitor, credit return, LFSR stimulus, timeout
 */

`timescale 1ns/1ns

module link_ctl_tb
    import link_ctl_pkg::*;
();

    localparam logic [7:0]  VER_MAJOR  = 8'h02;
    localparam logic [7:0]  VER_MINOR  = 8'h07;
    localparam logic [7:0]  DEV_ID     = 8'h3c;
    localparam logic [31:0] CUSTOM     = 32'h1234_5678;
    localparam int          CREDITS    = 4;
    localparam int          MAX_CYCLES = 4000;      // Tests need about 400 cycles

    logic              clk;
    logic              rst;
    logic              i_rx_valid;
    logic [LINK_W-1:0] i_rx_word;
    logic              i_tx_credit = 1'b0;
    logic              o_tx_valid;
    logic [LINK_W-1:0] o_tx_word;

    logic              credit_hold = 1'b0;          // Stops credit returns
    int                owed        = 0;             // Credits not yet returned
    int                tx_count    = 0;             // Words seen on the output
    int                cycles      = 0;
    logic [LINK_W-1:0] exp_q [$];                   // Expected output, in order
    logic [31:0]       lfsr_state  = 32'h01b0f945;
    logic [7:0]        ro_model [RO_BYTES];         // Byte images of both pages
    logic [7:0]        rw_model [RW_BYTES];

    tb_clkgen #(.PERIOD(10), .RST_CYCLES(3)) u_clkgen (.o_clk(clk), .o_rst(rst));

    link_ctl_top #(
        .VERSION_MAJOR (VER_MAJOR),
        .VERSION_MINOR (VER_MINOR),
        .DEVICE_ID     (DEV_ID),
        .CUSTOM_VALUE  (CUSTOM),
        .TX_CREDITS    (CREDITS)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_rx_valid  (i_rx_valid),
        .i_rx_word   (i_rx_word),
        .i_tx_credit (i_tx_credit),
        .o_tx_valid  (o_tx_valid),
        .o_tx_word   (o_tx_word)
    );

    // ----------------------------------------
    // Checking and run control
    // ----------------------------------------
    task automatic stop_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Finished with errors");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            stop_run("Timeout, tests did not finish within the cycle limit");
    end

    // Output monitor, strictly in order
    always @(posedge clk)
    begin
        if (!rst && o_tx_valid)
        begin
            if (exp_q.size() == 0)
                stop_run($sformatf("Output word %h with no expected word pending", o_tx_word));
            else
                check_eq(o_tx_word, exp_q.pop_front(), "output word");
            tx_count++;
        end
    end

    // Host side, one credit back per word received
    always @(posedge clk)
    begin
        if (rst)
        begin
            owed = 0;
            i_tx_credit <= 1'b0;
        end
        else
        begin
            if (o_tx_valid)
                owed = owed + 1;
            if (!credit_hold && owed > 0)
            begin
                i_tx_credit <= 1'b1;
                owed = owed - 1;
            end
            else
                i_tx_credit <= 1'b0;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            // Taps 32, 22, 2, 1
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic init_model();
        int i;
        for (i = 0; i < RO_BYTES; i++)
        begin
            ro_model[i] = 8'h00;
            rw_model[i] = 8'h00;                    // Scratch bytes clear
        end
        {ro_model[1], ro_model[0]} = RO_MAGIC;      // Little endian
        ro_model[4] = 8'(RO_BYTES);
        ro_model[8] = VER_MAJOR;
        ro_model[9] = VER_MINOR;
        ro_model[10] = DEV_ID;
        {ro_model[15], ro_model[14], ro_model[13], ro_model[12]} = CUSTOM;
        {rw_model[1], rw_model[0]} = RW_MAGIC;
        rw_model[2] = 8'(RW_BYTES);
    endtask

    // Read data as returned, byte at the address first
    function automatic logic [15:0] page_read(input logic [15:0] addr);
        int a;
        a = addr[14:0];
        if (a > 14)
            return 16'h0000;                        // Off the end of the page
        if (addr[ADDR_RW_BIT])
            return {rw_model[a], rw_model[a+1]};
        return {ro_model[a], ro_model[a+1]};
    endfunction

    function automatic logic [63:0] make_cmd(input logic rd, input logic wr, input logic [1:0] ctx,
                                             input logic [15:0] addr, input logic [15:0] mask,
                                             input logic [15:0] value);
        // mask and value given as {byte at addr+1, byte at addr}
        return {value[7:0], value[15:8], mask[7:0], mask[15:8],
                addr, 2'b00, wr, rd, ctx, TAG_CMD, LINK_MAGIC};
    endfunction

    function automatic logic [63:0] rsp_word(input logic [1:0] ctx, input logic [15:0] addr);
        return {addr, page_read(addr), 20'h00000, ctx, TAG_CMD, LINK_MAGIC};
    endfunction

    function automatic logic [63:0] loop_word(input logic [1:0] ctx, input logic [31:0] data);
        return {data, 20'h00000, ctx, TAG_LOOP, LINK_MAGIC};
    endfunction

    task automatic send_word(input logic [63:0] w);
        @(posedge clk);
        i_rx_valid <= 1'b1;
        i_rx_word  <= w;
    endtask

    task automatic rx_idle();
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    task automatic send_loop(input logic [1:0] ctx, input logic [31:0] data, input logic [19:0] junk);
        send_word({data, junk, ctx, TAG_LOOP, LINK_MAGIC});    // Bits 31:12 not forwarded
        exp_q.push_back(loop_word(ctx, data));
    endtask

    task automatic send_read(input logic [15:0] addr, input logic [1:0] ctx);
        send_word(make_cmd(1'b1, 1'b0, ctx, addr, 16'h0000, 16'h0000));
        exp_q.push_back(rsp_word(ctx, addr));
    endtask

    task automatic send_write(input logic [15:0] addr, input logic [15:0] mask,
                              input logic [15:0] value);
        int a;
        a = addr[14:0];
        send_word(make_cmd(1'b0, 1'b1, 2'b00, addr, mask, value));
        if (addr[ADDR_RW_BIT] && a <= 14)
        begin
            rw_model[a]   = (rw_model[a] & ~mask[7:0]) | (value[7:0] & mask[7:0]);
            rw_model[a+1] = (rw_model[a+1] & ~mask[15:8]) | (value[15:8] & mask[15:8]);
        end
    endtask

    task automatic set_hold(input logic h);
        @(posedge clk);
        credit_hold <= h;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // All expected words out and every credit handed back
    task automatic wait_settled();
        @(negedge clk);
        while (exp_q.size() != 0 || owed != 0 || i_tx_credit)
            @(negedge clk);
    endtask

    task automatic wait_count(input int target);
        @(negedge clk);
        while (tx_count < target)
            @(negedge clk);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_loopback();
        int n;
        for (n = 0; n < 12; n++)
            send_loop(2'(rand_bits(2)), rand_bits(32), 20'(rand_bits(20)));
        rx_idle();
        wait_settled();
    endtask

    task automatic test_filtering();
        send_word({32'hdead_beef, 20'h00000, 2'b01, TAG_LOOP, 8'h76});  // Bad magic
        send_word({32'h1111_2222, 20'h00000, 2'b00, TAG_TLP, LINK_MAGIC});
        send_word({32'h3333_4444, 20'h00000, 2'b10, TAG_CFG, LINK_MAGIC});
        send_word(make_cmd(1'b1, 1'b0, 2'b00, 16'h0000, 16'h0000, 16'h0000) ^ 64'h1);
        send_loop(2'b11, 32'h600d_f00d, 20'h00000);                     // Marker only
        rx_idle();
        wait_settled();
        idle_cycles(20);                            // Late words would show here
    endtask

    task automatic test_ro_page();
        logic [15:0] addrs [12];
        int          n;
        addrs = '{16'h0000, 16'h0002, 16'h0004, 16'h0006, 16'h0008, 16'h000a,
                  16'h000c, 16'h000e, 16'h0009, 16'h000f, 16'h0010, 16'h7ff0};
        for (n = 0; n < 12; n++)
            send_read(addrs[n], 2'(n));
        rx_idle();
        wait_settled();
    endtask

    task automatic test_rw_page();
        send_read(16'h8000, 2'b00);                 // RW_MAGIC
        send_read(16'h8002, 2'b01);                 // Byte count
        send_write(16'h8006, 16'hffff, 16'(rand_bits(16)));
        send_write(16'h8006, 16'hc30f, 16'(rand_bits(16)));     // Masked bits only
        send_read(16'h8006, 2'b10);
        send_write(16'h0008, 16'hffff, 16'haa55);   // Read-only page, ignored
        send_read(16'h0008, 2'b11);
        send_read(16'h8008, 2'b00);
        send_write(16'h800f, 16'hffff, 16'h1234);   // Crosses page end, ignored
        send_read(16'h800e, 2'b01);
        rx_idle();
        wait_settled();
    endtask

    task automatic test_credits();
        int base;
        int n;
        set_hold(1'b1);
        base = tx_count;
        for (n = 0; n < 8; n++)
            send_loop(2'(rand_bits(2)), rand_bits(32), 20'h00000);
        rx_idle();
        wait_count(base + CREDITS);
        idle_cycles(20);
        check_eq(64'(tx_count - base), 64'(CREDITS), "words sent without credit returns");
        check_eq(64'(exp_q.size()), 64'(8 - CREDITS), "words held back");
        set_hold(1'b0);
        wait_settled();
    endtask

    task automatic test_priority();
        logic [63:0] loop_exp;
        logic [63:0] rsp_exp;
        logic [31:0] data;
        int          base;
        int          n;
        set_hold(1'b1);
        base = tx_count;
        for (n = 0; n < CREDITS; n++)
            send_loop(2'(rand_bits(2)), rand_bits(32), 20'h00000);
        rx_idle();
        wait_count(base + CREDITS);                 // Credits used up
        data = rand_bits(32);
        send_word(make_cmd(1'b1, 1'b0, 2'b01, 16'h0008, 16'h0000, 16'h0000));
        rsp_exp = rsp_word(2'b01, 16'h0008);
        send_word({data, 20'h00000, 2'b10, TAG_LOOP, LINK_MAGIC});
        loop_exp = loop_word(2'b10, data);
        rx_idle();
        @(negedge clk);
        while (!(u_dut.loop_if.valid && u_dut.rsp_if.valid))
            @(negedge clk);
        exp_q.push_back(loop_exp);                  // Loopback wins
        exp_q.push_back(rsp_exp);
        set_hold(1'b0);
        wait_settled();
    endtask

    initial
    begin
        i_rx_valid = 1'b0;
        i_rx_word  = '0;
        init_model();
        @(negedge clk);
        while (rst)
            @(negedge clk);
        check_eq(64'(o_tx_valid), 64'h0, "o_tx_valid after reset");
        test_loopback();
        test_filtering();
        test_ro_page();
        test_rw_page();
        test_credits();
        test_priority();
        if (exp_q.size() == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            stop_run("Expected output words still missing at the end of the run");
    end

endmodule

//--- link_ctl.f
link_ctl_pkg.sv
link_src_if.sv
sync_fifo.sv
rx_router.sv
ctl_regfile.sv
tx_arbiter.sv
link_ctl_top.sv
tb_clkgen.sv
link_ctl_properties.sv
link_ctl_tb.sv

//--- Bender.yml
package:
  name: link_ctl

sources:
  - link_ctl_pkg.sv
  - link_src_if.sv
  - sync_fifo.sv
  - rx_router.sv
  - ctl_regfile.sv
  - tx_arbiter.sv
  - link_ctl_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - link_ctl_properties.sv
      - link_ctl_tb.sv
